/* hps_bridge.f */
hdl/hps_pkg.sv
hdl/host_cmd_if.sv
hdl/host_cmd_decode.sv
hdl/host_reg_bank.sv
hdl/file_download.sv
hdl/host_readback.sv
hdl/hps_bridge.sv
test/hps_checker.sv
test/tb_hps_bridge.sv

/* run_sim.sh */
#!/bin/sh
# builds the hps_bridge testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_hps_bridge -f hps_bridge.f \
	> build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vtb_hps_bridge > sim.log 2>&1 || echo "simulator returned an error status"
cat sim.log
grep -q '>>> FAIL' sim.log && { echo "simulation failed"; exit 1; }
grep -q '>>> PASS' sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0

/* test/tb_hps_bridge.sv */
// testbench for the hps bridge: host bus driver, random stimulus and reference model
module tb_hps_bridge;

	localparam int REG_ROUNDS    = 8;
	localparam int KEY_ROUNDS    = 12;
	localparam int DL_BYTES      = 16;
	localparam int REQ_ROUNDS    = 4;
	localparam int MASK_ROUNDS   = 4;
	// reset counts as one frame, each status round as two
	localparam int NUM_FRAMES    = REG_ROUNDS * 4 + KEY_ROUNDS + 4 + 5 +
		REQ_ROUNDS * 2 + MASK_ROUNDS * 2 + 1;
	localparam int MAX_FRAME_CYC = 64;
	localparam int WATCHDOG_TIME = NUM_FRAMES * MAX_FRAME_CYC * 4 * 2;

	logic                       clk_sys, reset;
	logic                       io_enable, io_strobe;
	logic [15:0]                io_din, io_dout;
	logic [31:0]                status_in;
	logic                       status_set;
	logic [15:0]                status_menumask, uart_mode;
	logic [1:0]                 buttons;
	logic                       forced_scandoubler;
	logic [31:0]                joystick_0, joystick_1, status;
	logic [10:0]                ps2_key;
	logic                       ioctl_download, ioctl_wr;
	logic [7:0]                 ioctl_index, ioctl_dout;
	logic [hps_pkg::ADDR_W-1:0] ioctl_addr;
	logic [31:0]                ioctl_file_ext;

	// model state
	logic [7:0]                 exp_cfg, exp_index, exp_wr_data;
	logic [31:0]                exp_joy0, exp_joy1, exp_status, exp_ext;
	logic [10:0]                exp_ps2_key;
	logic [15:0]                exp_dout;
	logic                       exp_download;
	logic [hps_pkg::ADDR_W-1:0] exp_addr, exp_wr_addr;
	int                         exp_writes;
	logic [3:0]                 req_count;
	logic [31:0]                req_value;

	logic                       check_req, test_done, run_done;
	int                         test_id, errors;
	logic [31:0]                lfsr;

	hps_bridge i_hps_bridge (
		.clk_sys(clk_sys), .reset(reset),
		.io_enable(io_enable), .io_strobe(io_strobe), .io_din(io_din), .io_dout(io_dout),
		.status_in(status_in), .status_set(status_set),
		.status_menumask(status_menumask), .uart_mode(uart_mode),
		.buttons(buttons), .forced_scandoubler(forced_scandoubler),
		.joystick_0(joystick_0), .joystick_1(joystick_1), .status(status), .ps2_key(ps2_key),
		.ioctl_download(ioctl_download), .ioctl_index(ioctl_index), .ioctl_wr(ioctl_wr),
		.ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout), .ioctl_file_ext(ioctl_file_ext)
	);

	hps_checker i_checker (
		.clk_sys(clk_sys), .check_req(check_req), .test_done(test_done),
		.test_id(test_id), .run_done(run_done),
		.io_dout(io_dout), .buttons(buttons), .forced_scandoubler(forced_scandoubler),
		.joystick_0(joystick_0), .joystick_1(joystick_1), .status(status), .ps2_key(ps2_key),
		.ioctl_download(ioctl_download), .ioctl_index(ioctl_index), .ioctl_wr(ioctl_wr),
		.ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout), .ioctl_file_ext(ioctl_file_ext),
		.exp_cfg(exp_cfg), .exp_joy0(exp_joy0), .exp_joy1(exp_joy1), .exp_status(exp_status),
		.exp_ps2_key(exp_ps2_key), .exp_dout(exp_dout), .exp_download(exp_download),
		.exp_index(exp_index), .exp_addr(exp_addr), .exp_ext(exp_ext),
		.exp_wr_addr(exp_wr_addr), .exp_wr_data(exp_wr_data), .exp_writes(exp_writes),
		.errors(errors)
	);

	// period 4
	always #2 clk_sys = ~clk_sys;

	// galois lfsr, one step per bit taken
	function automatic logic [31:0] lfsr_bits(input int n);
		logic [31:0] r;
		logic        b;
		r = '0;
		for (int i = 0; i < n; i++) begin
			b = lfsr[0];
			lfsr = lfsr >> 1;
			if (b)
				lfsr = lfsr ^ 32'h80200003;
			r = {r[30:0], b};
		end
		return r;
	endfunction

	////////////////////
	// bus driver
	////////////////////
	task automatic tick();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic pulse_check();
		check_req = 1'b1;
		tick();
		check_req = 1'b0;
	endtask

	// strobe, then two idle cycles, the first one sampled by the checker
	task automatic send_word(input logic [15:0] w);
		io_din    = w;
		io_strobe = 1'b1;
		tick();
		io_strobe = 1'b0;
		pulse_check();
		tick();
	endtask

	task automatic begin_frame(input hps_pkg::host_cmd_t cmd);
		io_enable = 1'b1;
		exp_dout  = (cmd == hps_pkg::CMD_STATUS_REQ) ? {8'h00, hps_pkg::REQ_TAG, req_count} : '0;
		tick();
		send_word(cmd);
	endtask

	task automatic end_frame();
		io_enable = 1'b0;
		exp_dout  = '0;
		tick();
		pulse_check();
		tick();
	endtask

	task automatic finish_test(input int id);
		test_id   = id;
		test_done = 1'b1;
		tick();
		test_done = 1'b0;
	endtask

	////////////////////
	// tests
	////////////////////
	task automatic reg_frame(input hps_pkg::host_cmd_t cmd);
		int          n;
		logic [15:0] w;
		n = (cmd == hps_pkg::CMD_CFG) ? 1 : 1 + int'(lfsr_bits(2)) % 3;
		begin_frame(cmd);
		for (int k = 1; k <= n; k++) begin
			w = 16'(lfsr_bits(16));
			case (cmd)
				hps_pkg::CMD_CFG: exp_cfg = w[7:0];
				hps_pkg::CMD_JOY0: exp_joy0 = (k == 1) ? {exp_joy0[31:16], w} : {w, exp_joy0[15:0]};
				hps_pkg::CMD_JOY1: exp_joy1 = (k == 1) ? {exp_joy1[31:16], w} : {w, exp_joy1[15:0]};
				hps_pkg::CMD_STATUS: exp_status = (k == 1) ? {exp_status[31:16], w} :
					(k == 2) ? {w, exp_status[15:0]} : exp_status;
				default: ;
			endcase
			send_word(w);
		end
		end_frame();
	endtask

	task automatic send_keys(input logic [31:0] bytes, input int nbytes, input int skip_pos,
		input logic [9:0] key_event);
		logic        skipped;
		logic [7:0]  b;
		skipped = 1'b0;
		begin_frame(hps_pkg::CMD_KBD);
		for (int i = nbytes - 1; i >= 0; i--) begin
			if (i == skip_pos) begin
				skipped = 1'b1;
				b = 8'(lfsr_bits(8));
				send_word({hps_pkg::KEY_SKIP, b});
			end
			b = bytes[8 * i +: 8];
			send_word({8'h00, b});
		end
		if (!skipped)
			exp_ps2_key = {~exp_ps2_key[10], key_event};
		end_frame();
	endtask

	task automatic test_keys();
		logic [7:0] code;
		int         form;
		for (int r = 0; r < KEY_ROUNDS; r++) begin
			form = int'(lfsr_bits(2));
			code = 8'(lfsr_bits(8));
			// pressed and extended flags follow from the prefix bytes of each form
			case (form)
				0: send_keys({24'h0, code}, 1, -1, {2'b10, code});
				1: send_keys({16'h0, hps_pkg::KEY_EXT, code}, 2, -1, {2'b11, code});
				2: send_keys({16'h0, hps_pkg::KEY_BREAK, code}, 2, -1, {2'b00, code});
				default: send_keys({8'h0, hps_pkg::KEY_EXT, hps_pkg::KEY_BREAK, code}, 3, -1,
					{2'b01, code});
			endcase
		end
		send_keys(hps_pkg::SEQ_PRNSCR_DOWN, 4, -1, hps_pkg::REP_PRNSCR_DOWN);
		send_keys(hps_pkg::SEQ_PRNSCR_UP, 4, -1, hps_pkg::REP_PRNSCR_UP);
		send_keys(hps_pkg::SEQ_PAUSE, 4, -1, hps_pkg::REP_PAUSE);
		// skip marker ahead of the last byte drops the whole event
		send_keys({16'h0, hps_pkg::KEY_BREAK, 8'h1C}, 2, 0, '0);
	endtask

	task automatic test_download();
		logic [15:0] w;
		begin_frame(hps_pkg::CMD_FILE_INDEX);
		w = 16'(lfsr_bits(16));
		exp_index = w[7:0];
		send_word(w);
		end_frame();
		begin_frame(hps_pkg::CMD_FILE_INFO);
		w = 16'(lfsr_bits(16));
		exp_ext[31:16] = w;
		send_word(w);
		w = 16'(lfsr_bits(16));
		exp_ext[15:0] = w;
		send_word(w);
		end_frame();
		begin_frame(hps_pkg::CMD_FILE_TX);
		exp_download = 1'b1;
		send_word(16'(lfsr_bits(16)) | 16'h0001);
		end_frame();
		begin_frame(hps_pkg::CMD_FILE_TX_DAT);
		for (int k = 0; k < DL_BYTES; k++) begin
			w           = 16'(lfsr_bits(16));
			exp_addr    = k[hps_pkg::ADDR_W-1:0];
			exp_wr_addr = k[hps_pkg::ADDR_W-1:0];
			exp_wr_data = w[7:0];
			send_word(w);
			exp_writes = exp_writes + 1;
		end
		end_frame();
		begin_frame(hps_pkg::CMD_FILE_TX);
		exp_download = 1'b0;
		exp_addr     = DL_BYTES;
		send_word(16'h0000);
		end_frame();
	endtask

	task automatic test_status_req();
		int pulses;
		for (int r = 0; r < REQ_ROUNDS; r++) begin
			pulses = 1 + int'(lfsr_bits(3));
			for (int p = 0; p < pulses; p++) begin
				status_in  = lfsr_bits(32);
				status_set = 1'b1;
				req_count  = req_count + 1'b1;
				req_value  = status_in;
				repeat (1 + int'(lfsr_bits(1))) tick();
				status_set = 1'b0;
				tick();
				status_in = lfsr_bits(32);
				tick();
			end
			begin_frame(hps_pkg::CMD_STATUS_REQ);
			exp_dout = req_value[15:0];
			send_word(16'(lfsr_bits(16)));
			exp_dout = req_value[31:16];
			send_word(16'(lfsr_bits(16)));
			end_frame();
		end
	endtask

	task automatic test_mask_uart();
		for (int r = 0; r < MASK_ROUNDS; r++) begin
			status_menumask = 16'(lfsr_bits(16));
			uart_mode       = 16'(lfsr_bits(16));
			begin_frame(hps_pkg::CMD_MENUMASK);
			exp_dout = status_menumask;
			send_word(16'(lfsr_bits(16)));
			exp_dout = '0;
			send_word(16'(lfsr_bits(16)));
			end_frame();
			begin_frame(hps_pkg::CMD_UART);
			exp_dout = uart_mode;
			send_word(16'(lfsr_bits(16)));
			uart_mode = 16'(lfsr_bits(16));
			exp_dout  = uart_mode;
			send_word(16'(lfsr_bits(16)));
			end_frame();
		end
	endtask

	initial begin
		#(WATCHDOG_TIME);
		$display("watchdog: simulation timed out at %0t before the tests finished", $time);
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		clk_sys = 1'b0;
		reset = 1'b1;
		io_enable = 1'b0;
		io_strobe = 1'b0;
		io_din = '0;
		status_in = '0;
		status_set = 1'b0;
		status_menumask = '0;
		uart_mode = '0;
		check_req = 1'b0;
		test_done = 1'b0;
		run_done = 1'b0;
		test_id = 0;
		lfsr = 32'd6;
		{exp_cfg, exp_index, exp_wr_data, exp_joy0, exp_joy1, exp_status, exp_ext} = '0;
		{exp_ps2_key, exp_dout, exp_download, exp_addr, exp_wr_addr} = '0;
		{req_count, req_value} = '0;
		exp_writes = 0;
		repeat (16) @(posedge clk_sys);
		#1;
		reset = 1'b0;
		tick();

		pulse_check();
		for (int r = 0; r < REG_ROUNDS; r++) begin
			reg_frame(hps_pkg::CMD_CFG);
			reg_frame(hps_pkg::CMD_JOY0);
			reg_frame(hps_pkg::CMD_JOY1);
			reg_frame(hps_pkg::CMD_STATUS);
		end
		finish_test(1);
		test_keys();
		finish_test(2);
		test_download();
		finish_test(3);
		test_status_req();
		finish_test(4);
		test_mask_uart();
		finish_test(5);

		run_done = 1'b1;
		tick();
		run_done = 1'b0;
		tick();
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

/* test/hps_checker.sv */
// response checker: compares the bridge outputs with the testbench model and keeps the counts
module hps_checker (
	input  logic                       clk_sys,
	// sequencing from the testbench
	input  logic                       check_req,
	input  logic                       test_done,
	input  int                         test_id,
	input  logic                       run_done,
	// DUT outputs
	input  logic [hps_pkg::IO_W-1:0]   io_dout,
	input  logic [1:0]                 buttons,
	input  logic                       forced_scandoubler,
	input  logic [31:0]                joystick_0,
	input  logic [31:0]                joystick_1,
	input  logic [31:0]                status,
	input  logic [10:0]                ps2_key,
	input  logic                       ioctl_download,
	input  logic [7:0]                 ioctl_index,
	input  logic                       ioctl_wr,
	input  logic [hps_pkg::ADDR_W-1:0] ioctl_addr,
	input  logic [7:0]                 ioctl_dout,
	input  logic [31:0]                ioctl_file_ext,
	// model state
	input  logic [7:0]                 exp_cfg,
	input  logic [31:0]                exp_joy0,
	input  logic [31:0]                exp_joy1,
	input  logic [31:0]                exp_status,
	input  logic [10:0]                exp_ps2_key,
	input  logic [hps_pkg::IO_W-1:0]   exp_dout,
	input  logic                       exp_download,
	input  logic [7:0]                 exp_index,
	input  logic [hps_pkg::ADDR_W-1:0] exp_addr,
	input  logic [31:0]                exp_ext,
	input  logic [hps_pkg::ADDR_W-1:0] exp_wr_addr,
	input  logic [7:0]                 exp_wr_data,
	input  int                         exp_writes,
	output int                         errors
);

	int err_count    = 0;
	int checks       = 0;
	int test_checks  = 0;
	int test_errors  = 0;
	int tests_run    = 0;
	int tests_failed = 0;
	int wr_seen      = 0;

	assign errors = err_count;

	function automatic string test_name(input int id);
		case (id)
			1: return "register writes";
			2: return "keyboard events";
			3: return "file download";
			4: return "status request";
			5: return "mask and uart readback";
			default: return "unknown";
		endcase
	endfunction

	task automatic compare(input string what, input logic [31:0] got, input logic [31:0] expected);
		checks++;
		test_checks++;
		if (got !== expected) begin
			err_count++;
			test_errors++;
			$display("FAILED %0t: %s is %h, expected %h", $time, what, got, expected);
		end
	endtask

	// outputs settle after the rising edge, so everything is sampled on the falling one
	always @(negedge clk_sys) begin
		if (check_req) begin
			compare("io_dout", 32'(io_dout), 32'(exp_dout));
			compare("buttons", 32'(buttons), 32'(exp_cfg[1:0]));
			compare("forced_scandoubler", 32'(forced_scandoubler), 32'(exp_cfg[4]));
			compare("joystick_0", joystick_0, exp_joy0);
			compare("joystick_1", joystick_1, exp_joy1);
			compare("status", status, exp_status);
			compare("ps2_key", 32'(ps2_key), 32'(exp_ps2_key));
			compare("ioctl_download", 32'(ioctl_download), 32'(exp_download));
			compare("ioctl_index", 32'(ioctl_index), 32'(exp_index));
			compare("ioctl_addr", 32'(ioctl_addr), 32'(exp_addr));
			compare("ioctl_file_ext", ioctl_file_ext, exp_ext);
			compare("write count", wr_seen, exp_writes);
		end

		// every write pulse carries the byte sent with the matching data word
		if (ioctl_wr) begin
			compare("write address", 32'(ioctl_addr), 32'(exp_wr_addr));
			compare("write data", 32'(ioctl_dout), 32'(exp_wr_data));
			compare("ioctl_download during write", 32'(ioctl_download), 32'd1);
			wr_seen++;
		end

		if (test_done) begin
			tests_run++;
			if (test_errors == 0) begin
				$display("test %0d %s: passed, %0d checks", test_id, test_name(test_id), test_checks);
			end else begin
				tests_failed++;
				$display("test %0d %s: failed, %0d of %0d checks wrong", test_id,
					test_name(test_id), test_errors, test_checks);
			end
			test_checks = 0;
			test_errors = 0;
		end

		if (run_done)
			$display("summary: %0d tests, %0d passed, %0d failed, %0d checks, %0d errors",
				tests_run, tests_run - tests_failed, tests_failed, checks, err_count);
	end

endmodule

/* hdl/hps_bridge.sv */
// hps bridge top: host command bus to core registers, key events and file download
module hps_bridge (
	input  logic                         clk_sys,
	input  logic                         reset,

	// host bus
	input  logic                         io_enable,
	input  logic                         io_strobe,
	input  logic [hps_pkg::IO_W-1:0]     io_din,
	output logic [hps_pkg::IO_W-1:0]     io_dout,

	// core status side
	input  logic [hps_pkg::STATUS_W-1:0] status_in,
	input  logic                         status_set,
	input  logic [hps_pkg::IO_W-1:0]     status_menumask,
	input  logic [hps_pkg::IO_W-1:0]     uart_mode,

	output logic [1:0]                   buttons,
	output logic                         forced_scandoubler,
	output logic [hps_pkg::JOY_W-1:0]    joystick_0,
	output logic [hps_pkg::JOY_W-1:0]    joystick_1,
	output logic [hps_pkg::STATUS_W-1:0] status,
	output logic [10:0]                  ps2_key,

	// download port
	output logic                         ioctl_download,
	output logic [7:0]                   ioctl_index,
	output logic                         ioctl_wr,
	output logic [hps_pkg::ADDR_W-1:0]   ioctl_addr,
	output logic [7:0]                   ioctl_dout,
	output logic [31:0]                  ioctl_file_ext
);

	host_cmd_if cmd_if ();

	host_cmd_decode i_decode (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.io_enable (io_enable),
		.io_strobe (io_strobe),
		.io_din    (io_din),
		.cmd_if    (cmd_if.decoder)
	);

	host_reg_bank i_reg_bank (
		.clk_sys            (clk_sys),
		.reset              (reset),
		.cmd_if             (cmd_if.consumer),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.status             (status),
		.ps2_key            (ps2_key)
	);

	file_download i_download (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.cmd_if         (cmd_if.consumer),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_file_ext (ioctl_file_ext)
	);

	host_readback i_readback (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.status_in       (status_in),
		.status_set      (status_set),
		.status_menumask (status_menumask),
		.uart_mode       (uart_mode),
		.cmd_if          (cmd_if.consumer),
		.io_dout         (io_dout)
	);

endmodule

/* hdl/host_readback.sv */
// host readback: status change request capture and the registered io_dout word
module host_readback (
	input  logic                         clk_sys,
	input  logic                         reset,
	input  logic [hps_pkg::STATUS_W-1:0] status_in,
	input  logic                         status_set,
	input  logic [hps_pkg::IO_W-1:0]     status_menumask,
	input  logic [hps_pkg::IO_W-1:0]     uart_mode,
	host_cmd_if.consumer                 cmd_if,
	output logic [hps_pkg::IO_W-1:0]     io_dout
);

	logic                         status_set_q;
	logic [3:0]                   req_cnt;
	logic [hps_pkg::STATUS_W-1:0] status_req;

	////////////////////
	// status change request
	////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			status_set_q <= 1'b0;
			req_cnt      <= '0;
			status_req   <= '0;
		end else begin
			status_set_q <= status_set;
			if (status_set && !status_set_q) begin
				req_cnt    <= req_cnt + 1'b1;
				status_req <= status_in;
			end
		end
	end

	////////////////////
	// readback word
	////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_dout <= '0;
		end else if (cmd_if.frame_end) begin
			io_dout <= '0;
		end else if (cmd_if.cmd_word) begin
			io_dout <= '0;
			// counter goes out with the command word itself
			if (cmd_if.data == hps_pkg::CMD_STATUS_REQ)
				io_dout <= {8'h00, hps_pkg::REQ_TAG, req_cnt};
		end else if (cmd_if.data_word) begin
			io_dout <= '0;
			case (cmd_if.cmd)
				hps_pkg::CMD_STATUS_REQ: begin
					if (cmd_if.word_idx == hps_pkg::WORD_FIRST)
						io_dout <= status_req[15:0];
					else if (cmd_if.word_idx == hps_pkg::WORD_SECOND)
						io_dout <= status_req[31:16];
				end
				hps_pkg::CMD_MENUMASK: begin
					if (cmd_if.word_idx == hps_pkg::WORD_FIRST)
						io_dout <= status_menumask;
				end
				hps_pkg::CMD_UART: io_dout <= uart_mode;
				default: ;
			endcase
		end
	end

endmodule

/* hdl/file_download.sv */
// file download engine: turns host transfer frames into ioctl byte writes
module file_download (
	input  logic                       clk_sys,
	input  logic                       reset,
	host_cmd_if.consumer               cmd_if,
	output logic                       ioctl_download,
	output logic [7:0]                 ioctl_index,
	output logic                       ioctl_wr,
	output logic [hps_pkg::ADDR_W-1:0] ioctl_addr,
	output logic [7:0]                 ioctl_dout,
	output logic [31:0]                ioctl_file_ext
);

	logic [hps_pkg::ADDR_W-1:0] addr;
	// write stage, ioctl_wr follows one clock later
	logic                       wr;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ioctl_download <= 1'b0;
			ioctl_index    <= '0;
			ioctl_wr       <= 1'b0;
			ioctl_addr     <= '0;
			ioctl_dout     <= '0;
			ioctl_file_ext <= '0;
			addr           <= '0;
			wr             <= 1'b0;
		end else begin
			ioctl_wr <= wr;
			wr       <= 1'b0;

			if (cmd_if.data_word) begin
				case (cmd_if.cmd)
					hps_pkg::CMD_FILE_TX: begin
						if (cmd_if.data != '0) begin
							ioctl_download <= 1'b1;
							addr           <= '0;
						end else begin
							// end of transfer shows the byte count
							ioctl_download <= 1'b0;
							ioctl_addr     <= addr;
						end
					end
					hps_pkg::CMD_FILE_TX_DAT: begin
						ioctl_addr <= addr;
						ioctl_dout <= cmd_if.data[7:0];
						addr       <= addr + 1'b1;
						wr         <= 1'b1;
					end
					hps_pkg::CMD_FILE_INDEX: ioctl_index <= cmd_if.data[7:0];
					hps_pkg::CMD_FILE_INFO: begin
						if (cmd_if.word_idx == hps_pkg::WORD_FIRST)
							ioctl_file_ext[31:16] <= cmd_if.data;
						else if (cmd_if.word_idx == hps_pkg::WORD_SECOND)
							ioctl_file_ext[15:0] <= cmd_if.data;
					end
					default: ;
				endcase
			end
		end
	end

	// host paces data words, so writes never run back to back
	a_wr_pulse: assert property (@(posedge clk_sys) disable iff (reset)
		ioctl_wr |=> !ioctl_wr);

endmodule

/* hdl/host_reg_bank.sv */
// host written registers: config byte, joysticks, status and the ps2 key event word
module host_reg_bank (
	input  logic                         clk_sys,
	input  logic                         reset,
	host_cmd_if.consumer                 cmd_if,
	output logic [1:0]                   buttons,
	output logic                         forced_scandoubler,
	output logic [hps_pkg::JOY_W-1:0]    joystick_0,
	output logic [hps_pkg::JOY_W-1:0]    joystick_1,
	output logic [hps_pkg::STATUS_W-1:0] status,
	output logic [10:0]                  ps2_key
);

	logic [7:0]  cfg;
	logic [31:0] key_raw;
	logic        key_skip;
	logic        pressed;
	logic        extended;
	logic [9:0]  key_next;

	assign buttons            = cfg[1:0];
	assign forced_scandoubler = cfg[4];

	////////////////////
	// key event decode
	////////////////////

	// byte before the code is the break prefix on release
	assign pressed = (key_raw[15:8] != hps_pkg::KEY_BREAK);

	// extended prefix sits one byte further back on release
	assign extended = pressed ? (key_raw[15:8] == hps_pkg::KEY_EXT) :
		(key_raw[23:16] == hps_pkg::KEY_EXT);

	always_comb begin
		key_next = {pressed, extended, key_raw[7:0]};
		if (key_raw == hps_pkg::SEQ_PRNSCR_DOWN)
			key_next = hps_pkg::REP_PRNSCR_DOWN;
		else if (key_raw == hps_pkg::SEQ_PRNSCR_UP)
			key_next = hps_pkg::REP_PRNSCR_UP;
		else if (key_raw == hps_pkg::SEQ_PAUSE)
			key_next = hps_pkg::REP_PAUSE;
	end

	////////////////////
	// register writes
	////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cfg        <= '0;
			joystick_0 <= '0;
			joystick_1 <= '0;
			status     <= '0;
			key_raw    <= '0;
			key_skip   <= 1'b0;
			ps2_key    <= '0;
		end else begin
			if (cmd_if.cmd_word) begin
				key_skip <= 1'b0;
				if (cmd_if.data == hps_pkg::CMD_KBD)
					key_raw <= '0;
			end

			if (cmd_if.data_word) begin
				case (cmd_if.cmd)
					hps_pkg::CMD_CFG: cfg <= cmd_if.data[7:0];
					hps_pkg::CMD_JOY0: begin
						if (cmd_if.word_idx == hps_pkg::WORD_FIRST)
							joystick_0[15:0] <= cmd_if.data;
						else
							joystick_0[31:16] <= cmd_if.data;
					end
					hps_pkg::CMD_JOY1: begin
						if (cmd_if.word_idx == hps_pkg::WORD_FIRST)
							joystick_1[15:0] <= cmd_if.data;
						else
							joystick_1[31:16] <= cmd_if.data;
					end
					hps_pkg::CMD_STATUS: begin
						if (cmd_if.word_idx == hps_pkg::WORD_FIRST)
							status[15:0] <= cmd_if.data;
						else if (cmd_if.word_idx == hps_pkg::WORD_SECOND)
							status[31:16] <= cmd_if.data;
					end
					hps_pkg::CMD_KBD: begin
						// skip marker drops the rest of the frame
						if (cmd_if.data[15:8] == hps_pkg::KEY_SKIP)
							key_skip <= 1'b1;
						else if (!key_skip)
							key_raw <= {key_raw[23:0], cmd_if.data[7:0]};
					end
					default: ;
				endcase
			end

			if (cmd_if.frame_end) begin
				key_skip <= 1'b0;
				if (cmd_if.cmd == hps_pkg::CMD_KBD && !key_skip)
					ps2_key <= {~ps2_key[10], key_next};
			end
		end
	end

	// event toggle moves only on the edge right after a frame closes
	a_key_toggle: assert property (@(posedge clk_sys) disable iff (reset)
		$changed(ps2_key[10]) |-> $past(cmd_if.frame_end));

endmodule

/* hdl/host_cmd_decode.sv */
// host bus framer: latches the command word and numbers the data words of a frame
module host_cmd_decode (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     io_enable,
	input  logic                     io_strobe,
	input  logic [hps_pkg::IO_W-1:0] io_din,
	host_cmd_if.decoder              cmd_if
);

	hps_pkg::host_cmd_t cmd_q;
	hps_pkg::word_idx_t idx_q;
	logic               en_q;
	logic               strobe;

	assign strobe = io_enable & io_strobe;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cmd_q <= hps_pkg::CMD_NONE;
			idx_q <= '0;
			en_q  <= 1'b0;
		end else begin
			en_q <= io_enable;
			if (!io_enable) begin
				cmd_q <= hps_pkg::CMD_NONE;
				idx_q <= '0;
			end else if (io_strobe) begin
				if (idx_q == '0)
					cmd_q <= hps_pkg::host_cmd_t'(io_din);
				// stick at the top for very long frames
				if (~&idx_q)
					idx_q <= idx_q + 1'b1;
			end
		end
	end

	assign cmd_if.cmd       = cmd_q;
	assign cmd_if.word_idx  = idx_q;
	assign cmd_if.data      = io_din;
	assign cmd_if.cmd_word  = strobe && (idx_q == '0);
	assign cmd_if.data_word = strobe && (idx_q != '0);
	assign cmd_if.frame_end = en_q && !io_enable;

	// the host leaves at least one idle cycle between strobes
	a_strobe_gap: assert property (@(posedge clk_sys) disable iff (reset)
		strobe |=> !strobe);

endmodule

/* hdl/host_cmd_if.sv */
// decoded host command frame, shared by the decoder and its consumers
interface host_cmd_if;

	// latched command, cleared one cycle after frame_end
	hps_pkg::host_cmd_t cmd;
	hps_pkg::word_idx_t word_idx;
	logic [hps_pkg::IO_W-1:0] data;

	// single cycle pulses
	logic cmd_word;
	logic data_word;
	logic frame_end;

	modport decoder (
		output cmd, word_idx, data,
		output cmd_word, data_word, frame_end
	);

	modport consumer (
		input cmd, word_idx, data,
		input cmd_word, data_word, frame_end
	);

endinterface

/* hdl/hps_pkg.sv */
// hps bridge shared definitions: command opcodes, bus widths and keyboard sequences
package hps_pkg;

	localparam int IO_W     = 16;
	localparam int STATUS_W = 32;
	localparam int JOY_W    = 32;
	localparam int ADDR_W   = 25;
	localparam int WIDX_W   = 10;

	// word index inside a frame, saturates at all ones
	typedef logic [WIDX_W-1:0] word_idx_t;

	localparam word_idx_t WORD_FIRST  = 10'd1;
	localparam word_idx_t WORD_SECOND = 10'd2;

	// host command opcodes, first word of every frame
	typedef enum logic [IO_W-1:0] {
		CMD_NONE        = 16'h0000,
		CMD_CFG         = 16'h0001,
		CMD_JOY0        = 16'h0002,
		CMD_JOY1        = 16'h0003,
		CMD_KBD         = 16'h0005,
		CMD_STATUS      = 16'h001E,
		CMD_UART        = 16'h0028,
		CMD_STATUS_REQ  = 16'h0029,
		CMD_MENUMASK    = 16'h002E,
		CMD_FILE_TX     = 16'h0053,
		CMD_FILE_TX_DAT = 16'h0054,
		CMD_FILE_INDEX  = 16'h0055,
		CMD_FILE_INFO   = 16'h0056
	} host_cmd_t;

	////////////////////
	// ps2 keyboard scan codes
	////////////////////
	localparam logic [7:0] KEY_SKIP  = 8'hFF;
	localparam logic [7:0] KEY_BREAK = 8'hF0;
	localparam logic [7:0] KEY_EXT   = 8'hE0;

	// multi-byte sequences that collapse to a single event
	localparam logic [31:0] SEQ_PRNSCR_DOWN = 32'hE012E07C;
	localparam logic [9:0]  REP_PRNSCR_DOWN = 10'h37C;
	localparam logic [31:0] SEQ_PRNSCR_UP   = 32'h7CE0F012;
	localparam logic [9:0]  REP_PRNSCR_UP   = 10'h17C;
	localparam logic [31:0] SEQ_PAUSE       = 32'hF014F077;
	localparam logic [9:0]  REP_PAUSE       = 10'h377;

	// tag nibble above the status request counter
	localparam logic [3:0] REQ_TAG = 4'hA;

endpackage
